// ==== sources.f ====
source/bridge_bus_pkg.sv
source/bridge_ctrl_pkg.sv
source/ctrl_sync.sv
source/bus_upsizer.sv
source/bus_isolator.sv
source/bus_bridge_top.sv
test/tb_bus_bridge.sv

// ==== Bender.yml ====
package:
  name: bus_bridge

sources:
  # Packages first, then the stages, then the top level
  - files:
      - source/bridge_bus_pkg.sv
      - source/bridge_ctrl_pkg.sv
      - source/ctrl_sync.sv
      - source/bus_upsizer.sv
      - source/bus_isolator.sv
      - source/bus_bridge_top.sv

  - target: test
    files:
      - test/tb_bus_bridge.sv

// ==== test/tb_bus_bridge.sv ====
// Self-checking testbench for the bus bridge top that runs as the simulation top with sources.f
`default_nettype none

module tb_bus_bridge;

   localparam int NumEntries     = 17;
   localparam int WatchdogCycles = NumEntries * 20 + 100;
   localparam int MaxXferCycles  = 16;

   typedef struct packed {
      logic                                      we;
      logic [bridge_bus_pkg::AddrWidth-1:0]      adr;
      bridge_bus_pkg::narrow_data_t              dat;
      logic [bridge_bus_pkg::NarrowSelWidth-1:0] sel;
      logic                                      iso;
      logic                                      exp_err;
   } entry_t;

   logic                                      clk_i;
   logic                                      rst_n_i;
   logic                                      fetch_en_i;
   logic                                      irq_i;
   logic                                      isolate_i;
   logic                                      fetch_en_o;
   logic                                      irq_o;
   logic                                      isolated_o;
   logic                                      nb_cyc_i;
   logic                                      nb_stb_i;
   logic                                      nb_we_i;
   logic [bridge_bus_pkg::AddrWidth-1:0]      nb_adr_i;
   bridge_bus_pkg::narrow_data_t              nb_dat_i;
   logic [bridge_bus_pkg::NarrowSelWidth-1:0] nb_sel_i;
   bridge_bus_pkg::narrow_data_t              nb_dat_o;
   logic                                      nb_ack_o;
   logic                                      nb_err_o;
   logic                                      wb_cyc_o;
   logic                                      wb_stb_o;
   logic                                      wb_we_o;
   logic [bridge_bus_pkg::AddrWidth-1:0]      wb_adr_o;
   bridge_bus_pkg::wide_data_u                wb_dat_o;
   bridge_bus_pkg::wide_sel_t                 wb_sel_o;
   bridge_bus_pkg::wide_data_u                wb_dat_i;
   logic                                      wb_ack_i;
   logic                                      wb_err_i;

   entry_t      stim [NumEntries];
   logic [63:0] slave_mem [16];
   logic [63:0] ref_mem [16];
   logic [31:0] lfsr_state;
   logic        cur_iso;

   bus_bridge_top dut (.*);

   always #4 clk_i = ~clk_i;

   function automatic entry_t make_entry(input logic we, input logic [31:0] adr,
                                         input logic [31:0] dat, input logic [3:0] sel,
                                         input logic iso, input logic exp_err);
      entry_t e;
      e.we      = we;
      e.adr     = adr;
      e.dat     = dat;
      e.sel     = sel;
      e.iso     = iso;
      e.exp_err = exp_err;
      return e;
   endfunction

   function automatic logic [63:0] fill_word(input logic [3:0] idx);
      return {8'h5a, idx, 20'h3c96e, 8'ha5, ~idx, 20'hc3691};
   endfunction

   // Galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic draw_bits(input int count, output int value);
      int k;
      value = 0;
      for (k = 0; k < count; k++) begin
         value      = (value << 1) | int'(lfsr_state[0]);
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   task automatic report_error(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_level(input string name, input logic exp_val, input logic act_val);
      if (act_val !== exp_val) begin
         report_error($sformatf("FAIL time %0t %s expected %b actual %b",
                                $time, name, exp_val, act_val));
      end
   endtask

   task automatic check_narrow_data(input bridge_bus_pkg::narrow_data_t exp_val,
                                    input bridge_bus_pkg::narrow_data_t act_val);
      if (act_val !== exp_val) begin
         report_error($sformatf("FAIL time %0t nb_dat_o expected %h actual %h",
                                $time, exp_val, act_val));
      end
   endtask

   task automatic check_resp(input logic exp_err, input logic act_ack, input logic act_err);
      if (act_ack !== !exp_err) begin
         report_error($sformatf("FAIL time %0t nb_ack_o expected %b actual %b",
                                $time, !exp_err, act_ack));
      end else if (act_err !== exp_err) begin
         report_error($sformatf("FAIL time %0t nb_err_o expected %b actual %b",
                                $time, exp_err, act_err));
      end
   endtask

   task automatic check_wide_req(input logic exp_we,
                                 input logic [bridge_bus_pkg::AddrWidth-1:0] exp_adr,
                                 input bridge_bus_pkg::wide_data_u exp_dat,
                                 input bridge_bus_pkg::wide_sel_t exp_sel);
      if (wb_stb_o !== 1'b1) begin
         report_error($sformatf("FAIL time %0t wb_stb_o expected %b actual %b",
                                $time, 1'b1, wb_stb_o));
      end else if (wb_we_o !== exp_we) begin
         report_error($sformatf("FAIL time %0t wb_we_o expected %b actual %b",
                                $time, exp_we, wb_we_o));
      end else if (wb_adr_o !== exp_adr) begin
         report_error($sformatf("FAIL time %0t wb_adr_o expected %h actual %h",
                                $time, exp_adr, wb_adr_o));
      end else if (wb_dat_o.whole !== exp_dat.whole) begin
         report_error($sformatf("FAIL time %0t wb_dat_o expected %h actual %h",
                                $time, exp_dat.whole, wb_dat_o.whole));
      end else if (wb_sel_o !== exp_sel) begin
         report_error($sformatf("FAIL time %0t wb_sel_o expected %h actual %h",
                                $time, exp_sel, wb_sel_o));
      end
   endtask

   task automatic wait_isolated(input logic level, input int max_cycles);
      int   n;
      logic reached;
      n       = 0;
      reached = 1'b0;
      while (!reached && n < max_cycles) begin
         @(negedge clk_i);
         n++;
         reached = (isolated_o === level);
      end
      if (!reached) begin
         report_error($sformatf("isolated_o did not reach %b within %0d cycles",
                                level, max_cycles));
      end
   endtask

   task automatic wait_ctrl(input logic exp_fetch, input logic exp_irq, input int max_cycles);
      int   n;
      logic reached;
      n       = 0;
      reached = 1'b0;
      while (!reached && n < max_cycles) begin
         @(negedge clk_i);
         n++;
         reached = (fetch_en_o === exp_fetch) && (irq_o === exp_irq);
      end
      if (!reached) begin
         report_error($sformatf("fetch_en_o and irq_o did not follow their inputs in %0d cycles",
                                max_cycles));
      end
   endtask

   // Byte merge of an acked narrow write into the reference copy
   task automatic ref_write(input entry_t e);
      int idx;
      int base;
      int b;
      idx  = e.adr[6:3];
      base = e.adr[2] ? 32 : 0;
      for (b = 0; b < 4; b++) begin
         if (e.sel[b]) begin
            ref_mem[idx][base+8*b +: 8] = e.dat[8*b +: 8];
         end
      end
   endtask

   task automatic run_transfer(input entry_t e);
      bridge_bus_pkg::wide_data_u           exp_dat;
      bridge_bus_pkg::wide_sel_t            exp_sel;
      logic [bridge_bus_pkg::AddrWidth-1:0] exp_adr;
      bridge_bus_pkg::narrow_data_t         exp_rdat;
      logic                                 seen_req;
      logic                                 done;
      int                                   n;
      // Narrow beat lands in the lane named by address bit 2
      exp_adr       = {e.adr[31:3], 3'b000};
      exp_dat.whole = e.adr[2] ? {e.dat, 32'h0} : {32'h0, e.dat};
      exp_sel       = e.adr[2] ? {e.sel, 4'h0} : {4'h0, e.sel};
      exp_rdat      = e.adr[2] ? ref_mem[e.adr[6:3]][63:32] : ref_mem[e.adr[6:3]][31:0];
      @(posedge clk_i);
      #1;
      nb_cyc_i = 1'b1;
      nb_stb_i = 1'b1;
      nb_we_i  = e.we;
      nb_adr_i = e.adr;
      nb_dat_i = e.dat;
      nb_sel_i = e.sel;
      seen_req = 1'b0;
      done     = 1'b0;
      n        = 0;
      while (!done && n < MaxXferCycles) begin
         @(negedge clk_i);
         n++;
         if (e.iso) begin
            check_level("wb_cyc_o", 1'b0, wb_cyc_o);
            check_level("wb_stb_o", 1'b0, wb_stb_o);
         end else if (wb_cyc_o && !seen_req) begin
            check_wide_req(e.we, exp_adr, exp_dat, exp_sel);
            seen_req = 1'b1;
         end
         done = nb_ack_o || nb_err_o;
      end
      if (!done) begin
         report_error($sformatf("narrow transfer to %h got neither ack nor err", e.adr));
      end
      if (!e.iso && !seen_req) begin
         report_error($sformatf("request to %h never reached the outbound port", e.adr));
      end
      check_resp(e.exp_err, nb_ack_o, nb_err_o);
      if (!e.we && !e.exp_err) begin
         check_narrow_data(exp_rdat, nb_dat_o);
      end
      if (e.we && !e.exp_err) begin
         ref_write(e);
      end
      // Master drops the cycle after sampling the response
      @(posedge clk_i);
      #1;
      nb_cyc_i = 1'b0;
      nb_stb_i = 1'b0;
      nb_we_i  = 1'b0;
      nb_adr_i = '0;
      nb_dat_i = '0;
      nb_sel_i = '0;
   endtask

   // Wide memory slave that acks 0 to 3 cycles late
   initial begin : wide_slave
      int wait_cycles;
      int idx;
      int b;
      lfsr_state = 32'hc849_5edd;
      wb_ack_i   = 1'b0;
      wb_err_i   = 1'b0;
      wb_dat_i   = '0;
      for (idx = 0; idx < 16; idx++) begin
         slave_mem[idx] = fill_word(idx[3:0]);
      end
      forever begin
         @(negedge clk_i);
         if (rst_n_i && wb_cyc_o && wb_stb_o) begin
            draw_bits(2, wait_cycles);
            @(posedge clk_i);
            repeat (wait_cycles) @(posedge clk_i);
            #1;
            idx = wb_adr_o[6:3];
            if (wb_we_o) begin
               for (b = 0; b < 8; b++) begin
                  if (wb_sel_o[b]) begin
                     slave_mem[idx][8*b +: 8] = wb_dat_o.whole[8*b +: 8];
                  end
               end
            end else begin
               wb_dat_i.whole = slave_mem[idx];
            end
            wb_ack_i = 1'b1;
            @(posedge clk_i);
            #1;
            wb_ack_i = 1'b0;
            wb_dat_i = '0;
         end
      end
   end

   initial begin : watchdog
      repeat (WatchdogCycles) @(posedge clk_i);
      report_error($sformatf("Timeout after %0d cycles without reaching the end of the test",
                             WatchdogCycles));
   end

   initial begin : main
      int i;
      clk_i      = 1'b0;
      rst_n_i    = 1'b0;
      fetch_en_i = 1'b0;
      irq_i      = 1'b0;
      isolate_i  = 1'b0;
      nb_cyc_i   = 1'b0;
      nb_stb_i   = 1'b0;
      nb_we_i    = 1'b0;
      nb_adr_i   = '0;
      nb_dat_i   = '0;
      nb_sel_i   = '0;
      for (i = 0; i < 16; i++) begin
         ref_mem[i] = fill_word(i[3:0]);
      end

      // we, address, data, selects, isolate, expect err
      stim[0]  = make_entry(1'b1, 32'h0000_0100, 32'h1122_3344, 4'hf, 1'b0, 1'b0);
      stim[1]  = make_entry(1'b1, 32'h0000_0104, 32'h5566_7788, 4'hf, 1'b0, 1'b0);
      stim[2]  = make_entry(1'b0, 32'h0000_0100, 32'h0,         4'hf, 1'b0, 1'b0);
      stim[3]  = make_entry(1'b0, 32'h0000_0104, 32'h0,         4'hf, 1'b0, 1'b0);
      stim[4]  = make_entry(1'b0, 32'h0000_0118, 32'h0,         4'hf, 1'b0, 1'b0);
      stim[5]  = make_entry(1'b0, 32'h0000_011c, 32'h0,         4'hf, 1'b0, 1'b0);
      stim[6]  = make_entry(1'b1, 32'h0000_0128, 32'haabb_ccdd, 4'h5, 1'b0, 1'b0);
      stim[7]  = make_entry(1'b1, 32'h0000_012c, 32'h0102_0304, 4'h8, 1'b0, 1'b0);
      stim[8]  = make_entry(1'b0, 32'h0000_0128, 32'h0,         4'hf, 1'b0, 1'b0);
      stim[9]  = make_entry(1'b0, 32'h0000_012c, 32'h0,         4'hf, 1'b0, 1'b0);
      stim[10] = make_entry(1'b1, 32'h8000_0054, 32'hcafe_f00d, 4'h3, 1'b0, 1'b0);
      stim[11] = make_entry(1'b0, 32'h8000_0054, 32'h0,         4'hf, 1'b0, 1'b0);
      stim[12] = make_entry(1'b1, 32'h0000_0140, 32'hdead_beef, 4'hf, 1'b1, 1'b1);
      stim[13] = make_entry(1'b0, 32'h0000_0128, 32'h0,         4'hf, 1'b1, 1'b1);
      stim[14] = make_entry(1'b0, 32'h0000_0140, 32'h0,         4'hf, 1'b0, 1'b0);
      stim[15] = make_entry(1'b1, 32'h0000_0144, 32'h1357_9bdf, 4'hf, 1'b0, 1'b0);
      stim[16] = make_entry(1'b0, 32'h0000_0144, 32'h0,         4'hf, 1'b0, 1'b0);

      repeat (4) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;

      // Synchronizer comes out of reset isolated
      @(negedge clk_i);
      check_level("isolated_o", 1'b1, isolated_o);
      wait_isolated(1'b0, bridge_ctrl_pkg::SyncStages + 2);

      @(posedge clk_i);
      #1;
      fetch_en_i = 1'b1;
      irq_i      = 1'b1;
      wait_ctrl(1'b1, 1'b1, bridge_ctrl_pkg::SyncStages + 1);
      @(posedge clk_i);
      #1;
      irq_i = 1'b0;
      wait_ctrl(1'b1, 1'b0, bridge_ctrl_pkg::SyncStages + 1);

      cur_iso = 1'b0;
      for (i = 0; i < NumEntries; i++) begin
         if (stim[i].iso !== cur_iso) begin
            @(posedge clk_i);
            #1;
            isolate_i = stim[i].iso;
            cur_iso   = stim[i].iso;
            wait_isolated(cur_iso, bridge_ctrl_pkg::SyncStages + 4);
         end
         run_transfer(stim[i]);
      end

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// ==== source/bus_bridge_top.sv ====
// Top level of the host bus bridge, the DUT for the testbench and the integration point
`default_nettype none

module bus_bridge_top (
   input  wire                                        clk_i,
   input  wire                                        rst_n_i,
   // Asynchronous control
   input  wire                                        fetch_en_i,
   input  wire                                        irq_i,
   input  wire                                        isolate_i,
   output logic                                       fetch_en_o,
   output logic                                       irq_o,
   output logic                                       isolated_o,
   // Narrow slave port towards the core
   input  wire                                        nb_cyc_i,
   input  wire                                        nb_stb_i,
   input  wire                                        nb_we_i,
   input  wire  [bridge_bus_pkg::AddrWidth-1:0]       nb_adr_i,
   input  wire  bridge_bus_pkg::narrow_data_t         nb_dat_i,
   input  wire  [bridge_bus_pkg::NarrowSelWidth-1:0]  nb_sel_i,
   output bridge_bus_pkg::narrow_data_t               nb_dat_o,
   output logic                                       nb_ack_o,
   output logic                                       nb_err_o,
   // Outbound wide master port
   output logic                                       wb_cyc_o,
   output logic                                       wb_stb_o,
   output logic                                       wb_we_o,
   output logic [bridge_bus_pkg::AddrWidth-1:0]       wb_adr_o,
   output bridge_bus_pkg::wide_data_u                 wb_dat_o,
   output bridge_bus_pkg::wide_sel_t                  wb_sel_o,
   input  wire  bridge_bus_pkg::wide_data_u           wb_dat_i,
   input  wire                                        wb_ack_i,
   input  wire                                        wb_err_i
);

   logic                                  isolate_sync;

   // Internal wide link between the upsizer and the isolator
   logic                                  up_cyc;
   logic                                  up_stb;
   logic                                  up_we;
   logic [bridge_bus_pkg::AddrWidth-1:0]  up_adr;
   bridge_bus_pkg::wide_data_u            up_wdat;
   bridge_bus_pkg::wide_sel_t             up_sel;
   bridge_bus_pkg::wide_data_u            up_rdat;
   logic                                  up_ack;
   logic                                  up_err;

   ctrl_sync #(
      .Stages     ( bridge_ctrl_pkg::SyncStages )
   ) i_ctrl_sync (
      .clk_i      ( clk_i        ),
      .rst_n_i    ( rst_n_i      ),
      .fetch_en_i ( fetch_en_i   ),
      .irq_i      ( irq_i        ),
      .isolate_i  ( isolate_i    ),
      .fetch_en_o ( fetch_en_o   ),
      .irq_o      ( irq_o        ),
      .isolate_o  ( isolate_sync )
   );

   bus_upsizer i_bus_upsizer (
      .clk_i    ( clk_i    ),
      .rst_n_i  ( rst_n_i  ),
      .nb_cyc_i ( nb_cyc_i ),
      .nb_stb_i ( nb_stb_i ),
      .nb_we_i  ( nb_we_i  ),
      .nb_adr_i ( nb_adr_i ),
      .nb_dat_i ( nb_dat_i ),
      .nb_sel_i ( nb_sel_i ),
      .nb_dat_o ( nb_dat_o ),
      .nb_ack_o ( nb_ack_o ),
      .nb_err_o ( nb_err_o ),
      .wb_cyc_o ( up_cyc   ),
      .wb_stb_o ( up_stb   ),
      .wb_we_o  ( up_we    ),
      .wb_adr_o ( up_adr   ),
      .wb_dat_o ( up_wdat  ),
      .wb_sel_o ( up_sel   ),
      .wb_dat_i ( up_rdat  ),
      .wb_ack_i ( up_ack   ),
      .wb_err_i ( up_err   )
   );

   bus_isolator i_bus_isolator (
      .clk_i      ( clk_i        ),
      .rst_n_i    ( rst_n_i      ),
      .isolate_i  ( isolate_sync ),
      .up_cyc_i   ( up_cyc       ),
      .up_stb_i   ( up_stb       ),
      .up_we_i    ( up_we        ),
      .up_adr_i   ( up_adr       ),
      .up_dat_i   ( up_wdat      ),
      .up_sel_i   ( up_sel       ),
      .up_dat_o   ( up_rdat      ),
      .up_ack_o   ( up_ack       ),
      .up_err_o   ( up_err       ),
      .wb_cyc_o   ( wb_cyc_o     ),
      .wb_stb_o   ( wb_stb_o     ),
      .wb_we_o    ( wb_we_o      ),
      .wb_adr_o   ( wb_adr_o     ),
      .wb_dat_o   ( wb_dat_o     ),
      .wb_sel_o   ( wb_sel_o     ),
      .wb_dat_i   ( wb_dat_i     ),
      .wb_ack_i   ( wb_ack_i     ),
      .wb_err_i   ( wb_err_i     ),
      .isolated_o ( isolated_o   )
   );

endmodule

`default_nettype wire

// ==== source/bus_isolator.sv ====
// Wide Wishbone pass stage that drains, cuts off the outbound port and answers with error
`default_nettype none

module bus_isolator (
   input  wire                                   clk_i,
   input  wire                                   rst_n_i,
   input  wire                                   isolate_i,
   // Upstream link from the upsizer
   input  wire                                   up_cyc_i,
   input  wire                                   up_stb_i,
   input  wire                                   up_we_i,
   input  wire  [bridge_bus_pkg::AddrWidth-1:0]  up_adr_i,
   input  wire  bridge_bus_pkg::wide_data_u      up_dat_i,
   input  wire  bridge_bus_pkg::wide_sel_t       up_sel_i,
   output bridge_bus_pkg::wide_data_u            up_dat_o,
   output logic                                  up_ack_o,
   output logic                                  up_err_o,
   // Outbound link
   output logic                                  wb_cyc_o,
   output logic                                  wb_stb_o,
   output logic                                  wb_we_o,
   output logic [bridge_bus_pkg::AddrWidth-1:0]  wb_adr_o,
   output bridge_bus_pkg::wide_data_u            wb_dat_o,
   output bridge_bus_pkg::wide_sel_t             wb_sel_o,
   input  wire  bridge_bus_pkg::wide_data_u      wb_dat_i,
   input  wire                                   wb_ack_i,
   input  wire                                   wb_err_i,
   output logic                                  isolated_o
);

   logic iso_q;
   logic iso_d;
   logic term_err_q;
   logic draining;
   logic pass;

   // Open or draining both pass traffic, draining just waits for the cycle to end
   assign pass     = !iso_q;
   assign draining = pass && isolate_i;

   // State changes only between cycles
   always_comb begin
      if (iso_q) begin
         iso_d = isolate_i || up_cyc_i;
      end else begin
         iso_d = draining && !up_cyc_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         iso_q      <= 1'b1;
         term_err_q <= 1'b0;
      end else begin
         iso_q      <= iso_d;
         // One err pulse per terminated request
         term_err_q <= iso_q && up_cyc_i && up_stb_i && !term_err_q;
      end
   end

   assign isolated_o = iso_q ? isolate_i : (draining && !up_cyc_i);

   assign wb_cyc_o = pass && up_cyc_i;
   assign wb_stb_o = pass && up_stb_i;
   assign wb_we_o  = up_we_i;
   assign wb_adr_o = up_adr_i;
   assign wb_dat_o = up_dat_i;
   assign wb_sel_o = up_sel_i;

   assign up_dat_o = pass ? wb_dat_i : '0;
   assign up_ack_o = pass && wb_ack_i;
   assign up_err_o = pass ? wb_err_i : term_err_q;

   // Reported isolation means nothing reaches the outbound port
   a_no_cyc_isolated : assert property (
      @(posedge clk_i) disable iff (!rst_n_i) isolated_o |-> !wb_cyc_o
   );

endmodule

`default_nettype wire

// ==== source/bus_upsizer.sv ====
// Registered 32-to-64-bit Wishbone classic stage that places write lanes and picks read lanes
`default_nettype none

module bus_upsizer (
   input  wire                                        clk_i,
   input  wire                                        rst_n_i,
   // Narrow slave side
   input  wire                                        nb_cyc_i,
   input  wire                                        nb_stb_i,
   input  wire                                        nb_we_i,
   input  wire  [bridge_bus_pkg::AddrWidth-1:0]       nb_adr_i,
   input  wire  bridge_bus_pkg::narrow_data_t         nb_dat_i,
   input  wire  [bridge_bus_pkg::NarrowSelWidth-1:0]  nb_sel_i,
   output bridge_bus_pkg::narrow_data_t               nb_dat_o,
   output logic                                       nb_ack_o,
   output logic                                       nb_err_o,
   // Wide master side
   output logic                                       wb_cyc_o,
   output logic                                       wb_stb_o,
   output logic                                       wb_we_o,
   output logic [bridge_bus_pkg::AddrWidth-1:0]       wb_adr_o,
   output bridge_bus_pkg::wide_data_u                 wb_dat_o,
   output bridge_bus_pkg::wide_sel_t                  wb_sel_o,
   input  wire  bridge_bus_pkg::wide_data_u           wb_dat_i,
   input  wire                                        wb_ack_i,
   input  wire                                        wb_err_i
);

   logic                                  busy_q;
   logic                                  ack_q;
   logic                                  err_q;
   logic                                  we_q;
   logic                                  lane_q;
   logic [bridge_bus_pkg::AddrWidth-1:0]  adr_q;
   bridge_bus_pkg::wide_data_u            dat_q;
   bridge_bus_pkg::wide_sel_t             sel_q;
   bridge_bus_pkg::narrow_data_t          rdat_q;

   logic                                  idle;
   logic                                  start;
   logic                                  rsp;
   logic                                  lane_d;
   bridge_bus_pkg::wide_data_u            dat_d;
   bridge_bus_pkg::wide_sel_t             sel_d;

   // Idle only once the narrow response has been seen, so a held stb is not taken twice
   assign idle   = !busy_q && !ack_q && !err_q;
   assign start  = idle && nb_cyc_i && nb_stb_i;
   assign rsp    = busy_q && (wb_ack_i || wb_err_i);
   assign lane_d = nb_adr_i[bridge_bus_pkg::LaneSelBit];

   // Lane placement, the unused lane and its selects stay 0
   always_comb begin
      dat_d = '0;
      sel_d = '0;
      dat_d.lanes[lane_d] = nb_dat_i;
      sel_d[lane_d*bridge_bus_pkg::NarrowSelWidth +: bridge_bus_pkg::NarrowSelWidth] = nb_sel_i;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         busy_q <= 1'b0;
         ack_q  <= 1'b0;
         err_q  <= 1'b0;
      end else begin
         ack_q <= rsp && wb_ack_i;
         err_q <= rsp && wb_err_i;
         if (start) begin
            busy_q <= 1'b1;
         end else if (rsp) begin
            busy_q <= 1'b0;
         end
      end
   end

   // Request and read data
   always_ff @(posedge clk_i) begin
      if (start) begin
         we_q   <= nb_we_i;
         lane_q <= lane_d;
         adr_q  <= {nb_adr_i[bridge_bus_pkg::AddrWidth-1:bridge_bus_pkg::LaneSelBit+1],
                    {(bridge_bus_pkg::LaneSelBit+1){1'b0}}};
         dat_q  <= dat_d;
         sel_q  <= sel_d;
      end
      if (rsp) begin
         rdat_q <= wb_dat_i.lanes[lane_q];
      end
   end

   assign nb_dat_o = rdat_q;
   assign nb_ack_o = ack_q;
   assign nb_err_o = err_q;

   // Single transfer per cycle, so stb tracks cyc
   assign wb_cyc_o = busy_q;
   assign wb_stb_o = busy_q;
   assign wb_we_o  = we_q;
   assign wb_adr_o = adr_q;
   assign wb_dat_o = dat_q;
   assign wb_sel_o = sel_q;

   // Downstream must never answer with ack and err together
   a_ack_err_onehot : assert property (
      @(posedge clk_i) disable iff (!rst_n_i) !(nb_ack_o && nb_err_o)
   );

   a_stb_in_cyc : assert property (
      @(posedge clk_i) disable iff (!rst_n_i) wb_stb_o |-> wb_cyc_o
   );

endmodule

`default_nettype wire

// ==== source/ctrl_sync.sv ====
// Synchronizer bank that brings fetch enable, interrupt and isolate into the clk_i domain
`default_nettype none

module ctrl_sync #(
   parameter int unsigned Stages = bridge_ctrl_pkg::SyncStages
) (
   input  wire  clk_i,
   input  wire  rst_n_i,
   input  wire  fetch_en_i,
   input  wire  irq_i,
   input  wire  isolate_i,
   output logic fetch_en_o,
   output logic irq_o,
   output logic isolate_o
);

   // Bit 0 fetch enable, bit 1 interrupt, bit 2 isolate
   logic [Stages-1:0][2:0]  sync_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         sync_q <= {Stages{bridge_ctrl_pkg::IsolateResetVal,
                           bridge_ctrl_pkg::IrqResetVal,
                           bridge_ctrl_pkg::FetchEnResetVal}};
      end else begin
         sync_q <= {sync_q[Stages-2:0], {isolate_i, irq_i, fetch_en_i}};
      end
   end

   assign fetch_en_o = sync_q[Stages-1][0];
   assign irq_o      = sync_q[Stages-1][1];
   assign isolate_o  = sync_q[Stages-1][2];

   // Bridge must start out isolated
   a_isolate_after_reset : assert property (
      @(posedge clk_i) $rose(rst_n_i) |-> isolate_o
   );

endmodule

`default_nettype wire

// ==== source/bridge_ctrl_pkg.sv ====
// Synchronizer depth and reset levels of the asynchronous control inputs
`default_nettype none

package bridge_ctrl_pkg;

   // Flops per synchronizer chain
   localparam int unsigned SyncStages = 3;

   localparam logic FetchEnResetVal = 1'b0;
   localparam logic IrqResetVal     = 1'b0;

   // Outbound port comes up cut off
   localparam logic IsolateResetVal = 1'b1;

endpackage

`default_nettype wire

// ==== source/bridge_bus_pkg.sv ====
// Bus widths, lane constants and data types shared by the narrow and wide Wishbone stages
`default_nettype none

package bridge_bus_pkg;

   // Core-side bus
   localparam int unsigned NarrowDataWidth = 32;
   localparam int unsigned NarrowSelWidth  = 4;

   // Outbound bus
   localparam int unsigned WideDataWidth   = 64;
   localparam int unsigned WideSelWidth    = 8;

   // Byte address, same on both sides
   localparam int unsigned AddrWidth       = 32;

   // Two narrow lanes per wide word, picked by address bit 2
   localparam int unsigned NumLanes        = 2;
   localparam int unsigned LaneSelBit      = 2;

   typedef logic [NarrowDataWidth-1:0] narrow_data_t;

   typedef logic [WideSelWidth-1:0] wide_sel_t;

   // Whole word for the outbound bus, lane array for the upsizer
   // Lane 0 sits in bits 31:0
   typedef union packed {
      logic [WideDataWidth-1:0]          whole;
      narrow_data_t [NumLanes-1:0]       lanes;
   } wide_data_u;

endpackage

`default_nettype wire
